/* build.f */
logic/core_pkg.sv
logic/ctrl_if.sv
logic/decode_control.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/alu.sv
logic/pc_unit.sv
logic/rv_core_top.sv
verification/rv_core_assertions.sv
verification/tb_rv_core.sv

/* logic/alu.sv */
`default_nettype none

module alu (
    ctrl_if.dp              dp,
    input  core_pkg::word_t rs1_val,
    input  core_pkg::word_t rs2_val,
    input  core_pkg::word_t imm,
    input  core_pkg::pc_t   pc,
    output core_pkg::word_t result,
    output logic            taken
);
    import core_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    always_comb begin
        unique case (dp.src_a)
            SRC_A_PC:   op_a = pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rs1_val;
        endcase
    end

    assign op_b  = (dp.src_b == SRC_B_IMM) ? imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        unique case (dp.alu_op)
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = $signed(op_a) >>> shamt;
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            default:  result = op_a + op_b;
        endcase
    end

    // compare always on the register values
    always_comb begin
        unique case (dp.br_cond)
            BR_EQ:   taken = (rs1_val == rs2_val);
            BR_NE:   taken = (rs1_val != rs2_val);
            BR_LT:   taken = ($signed(rs1_val) < $signed(rs2_val));
            BR_GE:   taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_LTU:  taken = (rs1_val < rs2_val);
            BR_GEU:  taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] pc_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;

    localparam pc_t RESET_PC = 32'h8000_0000;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 of OP / OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // srl / sra
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 of BRANCH
    localparam logic [2:0] BR_EQ  = 3'b000;
    localparam logic [2:0] BR_NE  = 3'b001;
    localparam logic [2:0] BR_LT  = 3'b100;
    localparam logic [2:0] BR_GE  = 3'b101;
    localparam logic [2:0] BR_LTU = 3'b110;
    localparam logic [2:0] BR_GEU = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_NONE
    } imm_fmt_t;

    typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_t;
    typedef enum logic       {SRC_B_RS2, SRC_B_IMM} src_b_t;
    typedef enum logic       {WB_ALU, WB_PC4} wb_sel_t;
    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} next_pc_t;

endpackage

`default_nettype wire

/* logic/ctrl_if.sv */
`default_nettype none

interface ctrl_if;
    import core_pkg::*;

    alu_op_t    alu_op;
    src_a_t     src_a;
    src_b_t     src_b;
    imm_fmt_t   imm_fmt;
    wb_sel_t    wb_sel;
    logic       reg_we;   // already low for rd == x0
    next_pc_t   pc_mode;
    logic [2:0] br_cond;  // branch funct3

    modport ctrl (
        output alu_op, src_a, src_b, imm_fmt, wb_sel, reg_we, pc_mode, br_cond
    );

    modport dp (
        input alu_op, src_a, src_b, imm_fmt, wb_sel, reg_we, pc_mode, br_cond
    );

endinterface

`default_nettype wire

/* logic/decode_control.sv */
`default_nettype none

module decode_control (
    input  core_pkg::instr_t   instr,
    ctrl_if.ctrl               ctrl,
    output core_pkg::reg_idx_t rs1,
    output core_pkg::reg_idx_t rs2,
    output core_pkg::reg_idx_t rd
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       write_rd;  // opcode writes rd, before the x0 check
    alu_op_t    arith_op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // funct3 -> alu op for OP and OP_IMM
    always_comb begin
        unique case (funct3)
            F3_ADD_SUB: arith_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SR:      arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:      arith_op = ALU_OR;
            default:    arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl.alu_op  = ALU_ADD;
        ctrl.src_a   = SRC_A_RS1;
        ctrl.src_b   = SRC_B_IMM;
        ctrl.imm_fmt = IMM_NONE;
        ctrl.wb_sel  = WB_ALU;
        ctrl.pc_mode = PC_SEQ;
        ctrl.br_cond = funct3;
        write_rd     = 1'b0;

        unique case (opcode)
            OPC_OP: begin
                ctrl.alu_op = arith_op;
                ctrl.src_b  = SRC_B_RS2;
                write_rd    = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.alu_op  = arith_op;
                ctrl.imm_fmt = IMM_I;
                write_rd     = 1'b1;
            end
            OPC_LUI: begin
                ctrl.src_a   = SRC_A_ZERO;
                ctrl.imm_fmt = IMM_U;
                write_rd     = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.src_a   = SRC_A_PC;
                ctrl.imm_fmt = IMM_U;
                write_rd     = 1'b1;
            end
            OPC_JAL: begin
                ctrl.src_a   = SRC_A_PC;  // alu forms pc + imm
                ctrl.imm_fmt = IMM_J;
                ctrl.wb_sel  = WB_PC4;
                ctrl.pc_mode = PC_JAL;
                write_rd     = 1'b1;
            end
            OPC_JALR: begin
                ctrl.imm_fmt = IMM_I;
                ctrl.wb_sel  = WB_PC4;
                ctrl.pc_mode = PC_JALR;
                write_rd     = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.imm_fmt = IMM_B;
                ctrl.pc_mode = PC_BRANCH;
            end
            default: ; // anything else retires as a nop
        endcase
    end

    assign ctrl.reg_we = write_rd && (rd != '0);

endmodule

`default_nettype wire

/* logic/imm_gen.sv */
`default_nettype none

module imm_gen (
    input  core_pkg::instr_t instr,
    ctrl_if.dp               dp,
    output core_pkg::word_t  imm
);
    import core_pkg::*;

    always_comb begin
        unique case (dp.imm_fmt)
            IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_U: imm = {instr[31:12], 12'b0};
            IMM_J: begin
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/pc_unit.sv */
`default_nettype none

module pc_unit (
    input  logic            clk,
    input  logic            reset,
    ctrl_if.dp              dp,
    input  core_pkg::word_t alu_result,
    input  core_pkg::word_t imm,
    input  logic            taken,
    output core_pkg::pc_t   pc,
    output core_pkg::pc_t   pc_plus4
);
    import core_pkg::*;

    pc_t next_pc;
    pc_t branch_target;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc + imm;

    always_comb begin
        unique case (dp.pc_mode)
            PC_BRANCH: next_pc = taken ? branch_target : pc_plus4;
            PC_JAL:    next_pc = alu_result;             // pc + imm
            PC_JALR:   next_pc = {alu_result[XLEN-1:1], 1'b0};
            default:   next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  core_pkg::reg_idx_t raddr1,
    input  core_pkg::reg_idx_t raddr2,
    output core_pkg::word_t    rdata1,
    output core_pkg::word_t    rdata2,
    input  logic               we,
    input  core_pkg::reg_idx_t waddr,
    input  core_pkg::word_t    wdata
);
    import core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && !reset) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero whatever is stored
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* logic/rv_core_top.sv */
`default_nettype none

module rv_core_top (
    input  logic               clk,
    input  logic               reset,
    input  core_pkg::instr_t   imem_data,
    output core_pkg::pc_t      imem_addr,
    output logic               retire_we,
    output core_pkg::reg_idx_t retire_rd,
    output core_pkg::word_t    retire_data
);
    import core_pkg::*;

    ctrl_if ctrl_bus ();

    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;
    word_t    alu_result;
    word_t    wb_data;
    pc_t      pc;
    pc_t      pc_plus4;
    logic     taken;
    logic     rf_we;

    decode_control u_decode (
        .instr (imem_data),
        .ctrl  (ctrl_bus.ctrl),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd)
    );

    imm_gen u_imm (
        .instr (imem_data),
        .dp    (ctrl_bus.dp),
        .imm   (imm)
    );

    assign rf_we   = ctrl_bus.reg_we;
    assign wb_data = (ctrl_bus.wb_sel == WB_PC4) ? pc_plus4 : alu_result; // link for jumps

    reg_file u_rf (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val),
        .we     (rf_we),
        .waddr  (rd),
        .wdata  (wb_data)
    );

    alu u_alu (
        .dp      (ctrl_bus.dp),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .imm     (imm),
        .pc      (pc),
        .result  (alu_result),
        .taken   (taken)
    );

    pc_unit u_pc (
        .clk        (clk),
        .reset      (reset),
        .dp         (ctrl_bus.dp),
        .alu_result (alu_result),
        .imm        (imm),
        .taken      (taken),
        .pc         (pc),
        .pc_plus4   (pc_plus4)
    );

    assign imem_addr   = pc;
    assign retire_we   = rf_we && !reset; // matches the write the reg file does
    assign retire_rd   = rd;
    assign retire_data = wb_data;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tb_rv_core -Mdir obj_dir -f build.f
./obj_dir/Vtb_rv_core | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* verification/rv_core_assertions.sv */
`default_nettype none

module rv_core_assertions (
    input logic               clk,
    input logic               reset,
    input core_pkg::pc_t      imem_addr,
    input logic               retire_we,
    input core_pkg::reg_idx_t retire_rd
);

    no_retire_in_reset: assert property (@(posedge clk) reset |-> !retire_we)
        else $error("retire_we high while reset is asserted");

    // pc is undefined until the first reset edge
    fetch_aligned: assert property (@(posedge clk) disable iff (reset) imem_addr[1:0] == 2'b00)
        else $error("imem_addr %08h not word aligned", imem_addr);

    no_x0_retire: assert property (@(posedge clk) retire_we |-> retire_rd != '0)
        else $error("retire_we high with retire_rd x0");

endmodule

bind rv_core_top rv_core_assertions u_assertions (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .retire_we (retire_we),
    .retire_rd (retire_rd)
);

`default_nettype wire

/* verification/rv_core_trace.txt */
// columns: instruction word, expected imem_addr, expected retire_we, retire_rd, retire_data
// rd and data are zero where nothing is written
00500093 80000000 1 01 00000005
FFD00113 80000004 1 02 FFFFFFFD
123451B7 80000008 1 03 12345000
00208233 8000000C 1 04 00000002
402082B3 80000010 1 05 00000008
00109333 80000014 1 06 000000A0
001123B3 80000018 1 07 00000001
00113433 8000001C 1 08 00000000
0020C4B3 80000020 1 09 FFFFFFF8
00115533 80000024 1 0A 07FFFFFF
401155B3 80000028 1 0B FFFFFFFF
0020E633 8000002C 1 0C FFFFFFFD
0020F6B3 80000030 1 0D 00000005
00112713 80000034 1 0E 00000001
00113793 80000038 1 0F 00000000
FFF0C813 8000003C 1 10 FFFFFFFA
0700E893 80000040 1 11 00000075
0FF17913 80000044 1 12 000000FD
00409993 80000048 1 13 00000050
01C15A13 8000004C 1 14 0000000F
40115A93 80000050 1 15 FFFFFFFE
00001B17 80000054 1 16 80001054
FFFFFBB7 80000058 1 17 FFFFF000
// branches, taken ones skip one word
00108463 8000005C 0 00 00000000
00208463 80000064 0 00 00000000
00209463 80000068 0 00 00000000
00109463 80000070 0 00 00000000
00114463 80000074 0 00 00000000
0020C463 8000007C 0 00 00000000
0020D463 80000080 0 00 00000000
00115463 80000088 0 00 00000000
0020E463 8000008C 0 00 00000000
00116463 80000094 0 00 00000000
00117463 80000098 0 00 00000000
0020F463 800000A0 0 00 00000000
// jal +12, then jalr to odd target
00C00C6F 800000A4 1 18 800000A8
011C0CE7 800000B0 1 19 800000B4
00708013 800000B8 0 00 00000000
00100D33 800000BC 1 1A 00000005
ABCDE037 800000C0 0 00 00000000
00006DB3 800000C4 1 1B 00000000
FFFFFFFF 800000C8 0 00 00000000
001D0E13 800000CC 1 1C 00000006

/* verification/tb_rv_core.sv */
`default_nettype none

module tb_rv_core;
    import core_pkg::*;

    localparam int TRACE_LEN    = 43;
    localparam int FIELDS       = 5;   // instr, pc, we, rd, data
    localparam int RESET_CYCLES = 10;
    localparam int CYCLE_LIMIT  = TRACE_LEN + RESET_CYCLES + 20;

    logic     clk;
    logic     reset;
    instr_t   imem_data;
    pc_t      imem_addr;
    logic     retire_we;
    reg_idx_t retire_rd;
    word_t    retire_data;

    logic [31:0] trace [TRACE_LEN*FIELDS];

    int pc_errors   = 0;
    int we_errors   = 0;
    int rd_errors   = 0;
    int data_errors = 0;
    int cycles      = 0;

    rv_core_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .retire_we   (retire_we),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %08h, actual %08h", name, expected, actual);
            pc_errors++;
        end
    endtask

    task automatic check_we(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %0b, actual %0b", name, expected, actual);
            we_errors++;
        end
    endtask

    task automatic check_rd(input string name, input reg_idx_t expected, input reg_idx_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected x%0d, actual x%0d", name, expected, actual);
            rd_errors++;
        end
    endtask

    task automatic check_data(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %08h, actual %08h", name, expected, actual);
            data_errors++;
        end
    endtask

    initial begin
        string tag;
        logic  exp_we;
        int    total;

        clk       = 1'b0;
        reset     = 1'b1;
        imem_data = 32'h0ff0_0093; // addi x1, x0, 255 would write outside reset
        $readmemh("verification/rv_core_trace.txt", trace);

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_we("reset retire_we", 1'b0, retire_we);
        end
        #1;
        reset = 1'b0;

        for (int i = 0; i < TRACE_LEN; i++) begin
            if (i > 0) begin
                @(posedge clk);
                #2;
            end
            imem_data = trace[i*FIELDS];
            @(negedge clk);
            tag    = $sformatf("instr %0d (%08h)", i, trace[i*FIELDS]);
            exp_we = trace[i*FIELDS+2][0];
            check_pc({tag, " imem_addr"}, trace[i*FIELDS+1], imem_addr);
            check_we({tag, " retire_we"}, exp_we, retire_we);
            if (exp_we) begin  // rd and data only mean something on a write
                check_rd({tag, " retire_rd"}, trace[i*FIELDS+3][4:0], retire_rd);
                check_data({tag, " retire_data"}, trace[i*FIELDS+4], retire_data);
            end
        end

        total = pc_errors + we_errors + rd_errors + data_errors;
        $display("errors: %0d total (pc %0d, we %0d, rd %0d, data %0d)",
                 total, pc_errors, we_errors, rd_errors, data_errors);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
